/* bench/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD = 2;	// 4 ns clock
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* bench/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb;
	import isa_pkg::*;
	import core_pkg::*;

	localparam int FM_ADDI = 0;
	localparam int FM_LI = 1;
	localparam int FM_ADDI_LO = 2;
	localparam int FM_LUI = 3;
	localparam int FM_SRLI = 4;
	localparam int FM_SRAI = 5;
	localparam int FM_SLLI = 6;
	localparam int FM_SRL = 7;
	localparam int FM_SRA = 8;
	localparam int FM_SLL = 9;
	localparam int FM_ANDI = 10;
	localparam int FM_ORI = 11;
	localparam int FM_SUB = 12;
	localparam int FM_OR = 13;
	localparam int FM_AND = 14;
	localparam int FM_XOR = 15;
	localparam int FM_MV = 16;
	localparam int FM_ADD = 17;
	localparam int FM_RSV = 18;
	localparam int NUM_FORMS = 19;

	localparam int RAND_CYCLES = 400;
	localparam int DIRECTED_CYCLES = 40;
	localparam int CYCLE_LIMIT = 10 + DIRECTED_CYCLES + RAND_CYCLES + 30;

	logic clk, reset;
	logic insn_valid, supmode;
	insn_t insn;
	logic res_valid, res_trap;
	reg_idx_t res_rd;
	word_t res_value;

	logic [31:0] lcg_state = 32'h2050;
	word_t model_regs [16];
	int exp_due[$];
	logic exp_trap[$];
	reg_idx_t exp_rd[$];
	word_t exp_value[$];
	int cyc = 0;
	int wd_cycles = 0;
	int results = 0;
	int value_errors = 0;
	int strobe_errors = 0;

	clock_gen clk_gen (
		.clk(clk),
		.reset(reset)
	);

	mini_core UUT (
		.clk(clk),
		.reset(reset),
		.insn_valid(insn_valid),
		.insn(insn),
		.supmode(supmode),
		.res_valid(res_valid),
		.res_rd(res_rd),
		.res_value(res_value),
		.res_trap(res_trap)
	);

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 15);	// mix high bits down
	endfunction

	function automatic logic is_protected(input reg_idx_t r);
		return r >= 4'd3 && r <= 4'd6;
	endfunction

	// builds the 16-bit word of one form from its register and immediate fields
	function automatic insn_t encode(input int form, input reg_idx_t rd, input reg_idx_t rs2,
		input int imm);
		logic [2:0] f3;
		logic b12, b11;
		logic [3:0] r;
		logic [4:0] lo;
		logic [1:0] q;
		logic [7:0] s;
		logic [15:0] w;
		s = imm[7:0];
		q = 2'b01;
		f3 = 3'b100;
		b12 = 1'b0;
		b11 = 1'b0;
		r = {1'b0, rd[2:0]};
		lo = '0;
		w = '0;
		case (form)
		FM_ADDI, FM_LI, FM_ADDI_LO: begin
			f3 = (form == FM_ADDI) ? 3'b000 : (form == FM_LI) ? 3'b010 : 3'b001;
			q = (form == FM_ADDI_LO) ? 2'b10 : 2'b01;
			r = {s[2], rd[2:0]};
			b12 = s[4];
			b11 = s[3];
			lo = {s[1:0], s[7], s[6:5]};
		end
		FM_LUI: begin
			f3 = 3'b011;
			r = rd;
			b11 = s[6];	// sign
			b12 = s[5];
			lo = s[4:0];
		end
		FM_SRLI, FM_SRAI, FM_SLLI: begin
			q = (form == FM_SLLI) ? 2'b11 : 2'b01;
			r[3] = (form == FM_SRAI);
			lo = {s[1:0], s[3:2], 1'b0};
		end
		FM_SRL, FM_SRA, FM_SLL: begin
			q = (form == FM_SLL) ? 2'b11 : 2'b01;
			r[3] = (form == FM_SRA);
			b12 = 1'b1;
			lo = {2'b00, rs2[2:0]};
		end
		FM_ANDI, FM_ORI: begin
			q = (form == FM_ORI) ? 2'b11 : 2'b01;
			b11 = 1'b1;
			b12 = s[4];
			lo = {s[1:0], s[3:2], s[5]};
		end
		FM_SUB: begin
			b11 = 1'b1;
			r[3] = 1'b1;
			lo = {1'b0, rs2};
		end
		FM_OR, FM_AND, FM_XOR: begin
			q = (form == FM_XOR) ? 2'b11 : 2'b01;
			b11 = 1'b1;
			r[3] = 1'b1;
			b12 = (form == FM_XOR);
			lo = {(form == FM_AND) ? 2'b11 : 2'b10, rs2[2:0]};
		end
		FM_MV, FM_ADD: begin
			q = 2'b10;
			r = rd;
			b12 = (form == FM_ADD);
			lo = {1'b0, rs2};
		end
		default: begin
			case (imm[17:16])
			2'b00: w = {imm[15:2], 2'b00};	// quadrant 0
			2'b01: w = {3'b101, imm[12:2], 2'b01};
			2'b10: w = {3'b000, imm[12:2], 2'b11};
			default: w = {3'b100, imm[12:6], 4'b0000, 2'b10};	// jr/jalr
			endcase
		end
		endcase
		if (form == FM_RSV)
			return w;
		return {f3, b12, b11, r, lo, q};
	endfunction

	task automatic run_model(input int form, input reg_idx_t rd, input reg_idx_t rs2,
		input int imm, input logic sup, output logic trap, output word_t value);
		reg_idx_t src1;
		logic use2;
		word_t a, b;
		src1 = (form == FM_LI || form == FM_LUI || form == FM_MV) ? 4'd0 : rd;
		use2 = (form >= FM_SRL && form <= FM_SLL) || (form >= FM_SUB && form <= FM_ADD);
		a = model_regs[src1];
		b = use2 ? model_regs[rs2] : word_t'(imm);
		case (form)
		FM_ADDI, FM_LI, FM_ADDI_LO, FM_ADD: value = a + b;
		FM_LUI: value = b << 8;
		FM_SRLI, FM_SRL: value = a >> b[4:0];
		FM_SRAI, FM_SRA: value = word_t'($signed(a) >>> b[4:0]);
		FM_SLLI, FM_SLL: value = a << b[4:0];
		FM_ANDI, FM_AND: value = a & b;
		FM_ORI, FM_OR: value = a | b;
		FM_XOR: value = a ^ b;
		FM_SUB: value = a - b;
		FM_MV: value = b;
		default: value = '0;
		endcase
		trap = (form == FM_RSV) || (!sup && (is_protected(rd) || is_protected(src1) ||
			(use2 && is_protected(rs2))));
		if (!trap && rd != 4'd0)
			model_regs[rd] = value;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		if (exp_due.size() > 0 && exp_due[0] == cyc) begin
			if (res_valid !== 1'b1) begin
				strobe_errors++;
				$display("%0t: no result strobe in cycle %0d, one was expected", $time, cyc);
			end else begin
				check_flag("res_trap", res_trap, exp_trap[0]);
				if (!exp_trap[0]) begin
					check_reg("res_rd", res_rd, exp_rd[0]);
					check_word("res_value", res_value, exp_value[0]);
				end
			end
			results++;
			void'(exp_due.pop_front());
			void'(exp_trap.pop_front());
			void'(exp_rd.pop_front());
			void'(exp_value.pop_front());
		end else if (res_valid !== 1'b0) begin
			strobe_errors++;
			$display("%0t: result strobe in cycle %0d with no instruction due", $time, cyc);
		end
	endtask

	// one cycle, inputs change on the falling edge
	task automatic tick(input logic valid, input insn_t word, input logic sup);
		check_outputs();
		insn_valid = valid;
		insn = word;
		supmode = sup;
		@(negedge clk);
		cyc++;
	endtask

	task automatic idle();
		tick(1'b0, '0, 1'b0);
	endtask

	task automatic issue(input int form, input reg_idx_t rd, input reg_idx_t rs2,
		input int imm, input logic sup);
		logic trap;
		word_t value;
		run_model(form, rd, rs2, imm, sup, trap, value);
		exp_due.push_back(cyc + 2);
		exp_trap.push_back(trap);
		exp_rd.push_back(rd);
		exp_value.push_back(value);
		tick(1'b1, encode(form, rd, rs2, imm), sup);
	endtask

	task automatic random_insn();
		logic [31:0] hi;
		int form, imm;
		reg_idx_t rd, rs2;
		hi = rand_next();
		form = int'(rand_next() % NUM_FORMS);
		rd = {1'b1, hi[2:0]};
		rs2 = {1'b1, hi[6:4]};
		imm = int'(hi[15:8]) - 128;
		case (form)
		FM_ADDI_LO: rd[3] = 1'b0;
		FM_LUI: begin
			rd = hi[3:0];
			if (rd == REG_SP)
				rd = 4'd0;
			imm = int'(hi[14:8]) - 64;
		end
		FM_SRLI, FM_SRAI, FM_SLLI: imm = int'(hi[11:8]);
		FM_ANDI, FM_ORI: imm = int'(hi[13:8]);
		FM_SUB: rs2 = hi[7:4];
		FM_MV, FM_ADD: begin
			rd = hi[3:0];
			rs2 = (hi[7:4] == 4'd0) ? 4'd1 : hi[7:4];
		end
		FM_RSV: imm = int'(rand_next());
		default: ;
		endcase
		issue(form, rd, rs2, imm, hi[24]);
	endtask

	always @(posedge clk) begin
		wd_cycles++;
		if (wd_cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		insn_valid = 1'b0;
		insn = '0;
		supmode = 1'b0;
		model_regs = '{default: '0};
		@(negedge reset);
		check_flag("res_valid", res_valid, 1'b0);
		check_flag("res_trap", res_trap, 1'b0);
		for (int i = 1; i < 16; i++)
			issue(FM_ADD, reg_idx_t'(i), reg_idx_t'(i), 0, 1'b1);	// all start at zero
		issue(FM_LI, 4'd9, 4'd0, -5, 1'b0);	// back to back, forwarded
		issue(FM_ADDI, 4'd9, 4'd0, 100, 1'b0);
		issue(FM_LUI, 4'd10, 4'd0, -3, 1'b0);
		issue(FM_ORI, 4'd10, 4'd0, 45, 1'b0);
		issue(FM_ANDI, 4'd10, 4'd0, 60, 1'b0);
		issue(FM_ADDI_LO, 4'd7, 4'd0, -128, 1'b0);
		issue(FM_SLLI, 4'd9, 4'd0, 15, 1'b0);
		issue(FM_SRA, 4'd10, 4'd9, 0, 1'b0);
		issue(FM_LUI, 4'd4, 4'd0, 17, 1'b0);	// user mode, traps
		issue(FM_MV, 4'd9, 4'd4, 0, 1'b1);
		issue(FM_LUI, 4'd4, 4'd0, 17, 1'b1);
		issue(FM_MV, 4'd9, 4'd4, 0, 1'b1);
		issue(FM_ADD, 4'd7, 4'd4, 0, 1'b0);
		issue(FM_ADDI_LO, 4'd0, 4'd0, 55, 1'b1);	// r0 write dropped
		issue(FM_SUB, 4'd8, 4'd0, 0, 1'b1);
		issue(FM_RSV, 4'd0, 4'd0, int'(rand_next()), 1'b1);
		for (int i = 0; i < RAND_CYCLES; i++) begin
			r = rand_next();
			if (r[3:2] == 2'b00)
				idle();
			else
				random_insn();
		end
		while (exp_due.size() > 0)
			idle();
		idle();
		$display("%0d results checked, %0d value errors, %0d strobe errors",
			results, value_errors, strobe_errors);
		if (value_errors == 0 && strobe_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/alu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
	input logic clk,
	input logic reset,
	input logic dec_valid,
	input core_pkg::alu_op_t dec_op,
	input core_pkg::reg_idx_t dec_rs1,
	input core_pkg::reg_idx_t dec_rs2,
	input core_pkg::reg_idx_t dec_rd,
	input logic dec_use_rs2,
	input core_pkg::word_t dec_imm,
	input logic dec_trap,
	output core_pkg::reg_idx_t rd_addr_a,
	output core_pkg::reg_idx_t rd_addr_b,
	input core_pkg::word_t rd_data_a,
	input core_pkg::word_t rd_data_b,
	output logic res_valid,
	output core_pkg::reg_idx_t res_rd,
	output core_pkg::word_t res_value,
	output logic res_trap
);
	import core_pkg::*;

	word_t src_a, src_b, op_b, alu_out;
	logic [SHAMT_W-1:0] shamt;
	logic fwd_ok;

	assign rd_addr_a = dec_rs1;
	assign rd_addr_b = dec_rs2;

	// result in flight is written at the end of this cycle
	assign fwd_ok = res_valid && !res_trap && res_rd != 4'd0;
	assign src_a = (fwd_ok && res_rd == dec_rs1) ? res_value : rd_data_a;
	assign src_b = (fwd_ok && res_rd == dec_rs2) ? res_value : rd_data_b;

	assign op_b = dec_use_rs2 ? src_b : dec_imm;
	assign shamt = op_b[SHAMT_W-1:0];

	always_comb begin
		case (dec_op)
		ADD: alu_out = src_a + op_b;
		SUB: alu_out = src_a - op_b;
		XOR: alu_out = src_a ^ op_b;
		OR: alu_out = src_a | op_b;
		AND: alu_out = src_a & op_b;
		SLL: alu_out = src_a << shamt;
		SRA: alu_out = word_t'($signed(src_a) >>> shamt);
		SRL: alu_out = src_a >> shamt;
		default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			res_trap <= 1'b0;
		end else begin
			res_valid <= dec_valid;
			res_trap <= dec_valid && dec_trap;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			res_rd <= dec_rd;
			res_value <= alu_out;
		end
	end

endmodule

`default_nettype wire

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int SHAMT_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [3:0] reg_idx_t;	// 16 registers

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		XOR = 3'd2,
		OR = 3'd3,
		AND = 3'd4,
		SLL = 3'd5,
		SRA = 3'd6,
		SRL = 3'd7
	} alu_op_t;

endpackage

`default_nettype wire

/* design/insn_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module insn_decode (
	input logic clk,
	input logic reset,
	input logic insn_valid,
	input isa_pkg::insn_t insn,
	input logic supmode,
	output logic dec_valid,
	output core_pkg::alu_op_t dec_op,
	output core_pkg::reg_idx_t dec_rs1,
	output core_pkg::reg_idx_t dec_rs2,
	output core_pkg::reg_idx_t dec_rd,
	output logic dec_use_rs2,
	output core_pkg::word_t dec_imm,
	output logic dec_trap
);
	import isa_pkg::*;
	import core_pkg::*;

	alu_op_t c_op;
	reg_idx_t c_rs1, c_rs2, c_rd;
	logic c_use_rs2, c_trap, c_priv;
	word_t c_imm, ci_imm, sp_imm, lui_imm, sh_imm;
	logic sh_rsv;

	function automatic logic is_priv(input reg_idx_t r);
		return r >= REG_PRIV_LO && r <= REG_PRIV_HI;
	endfunction

	assign ci_imm = {{(XLEN-7){insn.ci.imm_lo[2]}}, insn.ci.imm_lo[1:0], insn.ci.imm_b12,
		insn.ci.b11, insn.ci.rd_rs1[3], insn.ci.imm_lo[4:3]};
	assign sp_imm = {{(XLEN-8){insn.ci.imm_lo[2]}}, insn.ci.imm_lo[1:0], insn.ci.imm_b12,
		insn.ci.b11, insn.ci.imm_lo[3], insn.ci.imm_lo[4], 2'b00};	// word scaled
	assign lui_imm = {{(XLEN-14){insn.ci.b11}}, insn.ci.imm_b12, insn.ci.imm_lo, 8'b0};
	assign sh_imm = {{(XLEN-6){1'b0}}, insn.ci.imm_lo[0], insn.ci.imm_b12,
		insn.ci.imm_lo[2:1], insn.ci.imm_lo[4:3]};
	assign sh_rsv = insn.ci.imm_b12 ? (insn.ci.imm_lo[4:3] != 2'b00) : insn.ci.imm_lo[0];

	always_comb begin
		c_op = ADD;
		c_rs1 = '0;
		c_rs2 = '0;
		c_rd = '0;
		c_use_rs2 = 1'b0;
		c_imm = '0;
		c_trap = 1'b0;
		case (insn.ci.quad)
		QUAD_0: c_trap = 1'b1;	// loads and stores not carried
		QUAD_1: case (insn.ci.funct3)
			F3_ADDI, F3_LI: begin
				c_rd = {1'b1, insn.ci.rd_rs1[2:0]};
				c_rs1 = (insn.ci.funct3 == F3_LI) ? 4'd0 : {1'b1, insn.ci.rd_rs1[2:0]};
				c_imm = ci_imm;
			end
			F3_LUI: if (insn.ci.rd_rs1 == REG_SP) begin
				c_rd = REG_SP;
				c_rs1 = REG_SP;
				c_imm = sp_imm;
			end else begin
				c_rd = insn.ci.rd_rs1;
				c_imm = lui_imm;
			end
			F3_ALU: begin
				c_rd = {1'b1, insn.ci.rd_rs1[2:0]};
				c_rs1 = {1'b1, insn.ci.rd_rs1[2:0]};
				c_rs2 = {1'b1, insn.ci.imm_lo[2:0]};
				c_imm = sh_imm;
				case ({insn.ci.b11, insn.ci.rd_rs1[3]})
				2'b00, 2'b01: begin
					c_op = insn.ci.rd_rs1[3] ? SRA : SRL;
					c_use_rs2 = insn.ci.imm_b12;	// register amount
					c_trap = sh_rsv;
				end
				2'b10: c_op = AND;
				default: begin
					c_use_rs2 = 1'b1;
					casez ({insn.ci.imm_b12, insn.ci.imm_lo[4:3]})
					3'b00?: begin
						c_op = SUB;
						c_rs2 = insn.ci.imm_lo[3:0];	// full 16 register range
					end
					3'b010: c_op = OR;
					3'b011: c_op = AND;
					default: c_trap = 1'b1;
					endcase
				end
				endcase
			end
			default: c_trap = 1'b1;
			endcase
		QUAD_2: case (insn.cr.funct3)
			F3_ADDI_LO: begin
				c_rd = {1'b0, insn.ci.rd_rs1[2:0]};
				c_rs1 = {1'b0, insn.ci.rd_rs1[2:0]};
				c_imm = ci_imm;
			end
			F3_CR: begin
				c_rd = insn.cr.rd_rs1;
				c_rs1 = insn.cr.flag ? insn.cr.rd_rs1 : 4'd0;	// mv adds to zero
				c_rs2 = insn.cr.rs2;
				c_use_rs2 = 1'b1;
				c_trap = insn.cr.rsv11 || insn.cr.rsv6 || insn.cr.rs2 == 4'd0;	// jr/jalr
			end
			default: c_trap = 1'b1;
			endcase
		QUAD_3: if (insn.ci.funct3 == F3_ALU) begin
			c_rd = {1'b1, insn.ci.rd_rs1[2:0]};
			c_rs1 = {1'b1, insn.ci.rd_rs1[2:0]};
			c_rs2 = {1'b1, insn.ci.imm_lo[2:0]};
			c_imm = sh_imm;
			case ({insn.ci.b11, insn.ci.rd_rs1[3]})
			2'b00: begin
				c_op = SLL;
				c_use_rs2 = insn.ci.imm_b12;
				c_trap = sh_rsv;
			end
			2'b10: c_op = OR;
			2'b11: begin
				c_op = XOR;
				c_use_rs2 = 1'b1;
				c_trap = {insn.ci.imm_b12, insn.ci.imm_lo[4:3]} != 3'b110;
			end
			default: c_trap = 1'b1;
			endcase
		end else begin
			c_trap = 1'b1;
		end
		endcase
	end

	// user mode may not touch 3..6
	assign c_priv = !supmode && (is_priv(c_rd) || is_priv(c_rs1) ||
		(c_use_rs2 && is_priv(c_rs2)));

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_trap <= 1'b0;
		end else begin
			dec_valid <= insn_valid;
			if (insn_valid)
				dec_trap <= c_trap || c_priv;
		end
	end

	always_ff @(posedge clk) begin
		if (insn_valid) begin
			dec_op <= c_op;
			dec_rs1 <= c_rs1;
			dec_rs2 <= c_rs2;
			dec_rd <= c_rd;
			dec_use_rs2 <= c_use_rs2;
			dec_imm <= c_imm;
		end
	end

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	localparam logic [1:0] QUAD_0 = 2'b00;
	localparam logic [1:0] QUAD_1 = 2'b01;
	localparam logic [1:0] QUAD_2 = 2'b10;
	localparam logic [1:0] QUAD_3 = 2'b11;

	// quadrant 1
	localparam logic [2:0] F3_ADDI = 3'b000;	// high registers 8..15
	localparam logic [2:0] F3_LI = 3'b010;
	localparam logic [2:0] F3_LUI = 3'b011;	// addi to sp when rd is sp
	localparam logic [2:0] F3_ALU = 3'b100;	// shifts and logic, quadrant 3 too

	// quadrant 2
	localparam logic [2:0] F3_ADDI_LO = 3'b001;	// low registers 0..7
	localparam logic [2:0] F3_CR = 3'b100;	// mv and add

	localparam logic [3:0] REG_PRIV_LO = 4'd3;
	localparam logic [3:0] REG_PRIV_HI = 4'd6;
	localparam logic [3:0] REG_SP = 4'd2;

	// immediate view, bits 12 and 11 also carry sub-op selects
	typedef struct packed {
		logic [2:0] funct3;
		logic imm_b12;
		logic b11;
		logic [3:0] rd_rs1;
		logic [4:0] imm_lo;	// ins[6:2]
		logic [1:0] quad;
	} ci_t;

	// register view
	typedef struct packed {
		logic [2:0] funct3;
		logic flag;	// 0 mv, 1 add
		logic rsv11;
		logic [3:0] rd_rs1;
		logic rsv6;
		logic [3:0] rs2;
		logic [1:0] quad;
	} cr_t;

	typedef union packed {
		ci_t ci;
		cr_t cr;
	} insn_t;

endpackage

`default_nettype wire

/* design/mini_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mini_core (
	input logic clk,
	input logic reset,
	input logic insn_valid,
	input isa_pkg::insn_t insn,
	input logic supmode,
	output logic res_valid,
	output core_pkg::reg_idx_t res_rd,
	output core_pkg::word_t res_value,
	output logic res_trap
);
	import core_pkg::*;

	logic dec_valid, dec_use_rs2, dec_trap;
	alu_op_t dec_op;
	reg_idx_t dec_rs1, dec_rs2, dec_rd;
	word_t dec_imm;
	reg_idx_t rd_addr_a, rd_addr_b;
	word_t rd_data_a, rd_data_b;

	insn_decode u_decode (
		.clk(clk),
		.reset(reset),
		.insn_valid(insn_valid),
		.insn(insn),
		.supmode(supmode),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2),
		.dec_rd(dec_rd),
		.dec_use_rs2(dec_use_rs2),
		.dec_imm(dec_imm),
		.dec_trap(dec_trap)
	);

	alu_execute u_execute (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2),
		.dec_rd(dec_rd),
		.dec_use_rs2(dec_use_rs2),
		.dec_imm(dec_imm),
		.dec_trap(dec_trap),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.res_valid(res_valid),
		.res_rd(res_rd),
		.res_value(res_value),
		.res_trap(res_trap)
	);

	reg_writeback u_regs (
		.clk(clk),
		.reset(reset),
		.res_valid(res_valid),
		.res_trap(res_trap),
		.res_rd(res_rd),
		.res_value(res_value),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

endmodule

`default_nettype wire

/* design/reg_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_writeback (
	input logic clk,
	input logic reset,
	input logic res_valid,
	input logic res_trap,
	input core_pkg::reg_idx_t res_rd,
	input core_pkg::word_t res_value,
	input core_pkg::reg_idx_t rd_addr_a,
	input core_pkg::reg_idx_t rd_addr_b,
	output core_pkg::word_t rd_data_a,
	output core_pkg::word_t rd_data_b
);
	import core_pkg::*;

	word_t regs [16];
	logic wr_en;

	assign wr_en = res_valid && !res_trap && res_rd != 4'd0;	// r0 stays zero

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[res_rd] <= res_value;
		end
	end

	assign rd_data_a = (rd_addr_a == 4'd0) ? word_t'(0) : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == 4'd0) ? word_t'(0) : regs[rd_addr_b];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module core_tb \
	-f sources.f -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sources.f */
design/isa_pkg.sv
design/core_pkg.sv
design/insn_decode.sv
design/alu_execute.sv
design/reg_writeback.sv
design/mini_core.sv
bench/clock_gen.sv
bench/core_tb.sv
